//--- common/vector_consts.svh
// Vector dot product constants
// Widths, register map and reset values

`ifndef VECTOR_CONSTS_SVH
`define VECTOR_CONSTS_SVH

// Element and product widths
`define VEC_DATA_WIDTH 16
`define VEC_ACC_WIDTH (2 * `VEC_DATA_WIDTH)

// Vector length field, lengths 1 to 255
`define VEC_LEN_WIDTH 8

// Configuration register map
`define VEC_CFG_ADDR_WIDTH 2
`define VEC_ADDR_LENGTH 2'd0
`define VEC_ADDR_MODE 2'd1
`define VEC_ADDR_STATUS 2'd2

// Length after reset
`define VEC_RESET_LENGTH 8'd1

`endif

//--- common/vector_pkg.sv
// Vector dot product package
// Controller state and accumulate mode types shared by the datapath

`default_nettype none

package vector_pkg;

  ////////////////////
  // Controller FSM
  ////////////////////

  typedef enum logic [2:0] {
    // Wait for start
    IDLE         = 3'd0,
    // Element request strobe
    REQUEST      = 3'd1,
    // Collect operands a and b in any order
    WAIT_ELEM    = 3'd2,
    // Multiplier launch cycle
    MULTIPLY     = 3'd3,
    // Wait for the product, then add or subtract with saturation
    ACCUMULATE   = 3'd4,
    // Advance the index or finish
    UPDATE_INDEX = 3'd5
  } ctrl_state_e;

  ////////////////////
  // Accumulate mode
  ////////////////////

  typedef enum logic [0:0] {
    // sum + a*b
    ACC_ADD = 1'b0,
    // sum - a*b, negated dot product
    ACC_SUB = 1'b1
  } acc_mode_e;

endpackage

`default_nettype wire

//--- hw/vector_config_regs.sv
// Vector configuration registers
// Length, accumulate mode and sticky overflow status with readback

`default_nettype none

`include "vector_consts.svh"

module vector_config_regs (
  input  logic                          CLK,
  input  logic                          RST,
  input  logic                          cfg_we,
  input  logic [`VEC_CFG_ADDR_WIDTH-1:0] cfg_addr,
  input  logic [`VEC_ACC_WIDTH-1:0]     cfg_wdata,
  output logic [`VEC_ACC_WIDTH-1:0]     cfg_rdata,
  input  logic                          ovf,
  output logic [`VEC_LEN_WIDTH-1:0]     length,
  output vector_pkg::acc_mode_e         mode
);

  import vector_pkg::*;

  localparam logic [`VEC_LEN_WIDTH-1:0] MIN_LENGTH = 1;

  logic [`VEC_LEN_WIDTH-1:0] wdata_len;
  logic                      ovf_sticky;

  // Upper bits of the write word are dropped
  assign wdata_len = cfg_wdata[`VEC_LEN_WIDTH-1:0];

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      length     <= `VEC_RESET_LENGTH;
      mode       <= ACC_ADD;
      ovf_sticky <= 1'b0;
    end else begin
      if (cfg_we && cfg_addr == `VEC_ADDR_LENGTH) begin
        // Zero length is not legal, force one element
        length <= (wdata_len == '0) ? MIN_LENGTH : wdata_len;
      end
      if (cfg_we && cfg_addr == `VEC_ADDR_MODE) begin
        mode <= acc_mode_e'(cfg_wdata[0]);
      end
      // New overflow beats a clear in the same cycle
      if (ovf) begin
        ovf_sticky <= 1'b1;
      end else if (cfg_we && cfg_addr == `VEC_ADDR_STATUS) begin
        ovf_sticky <= 1'b0;
      end
    end
  end

  ////////////////////
  // Readback
  ////////////////////

  always_comb begin
    case (cfg_addr)
      `VEC_ADDR_LENGTH: cfg_rdata = {{(`VEC_ACC_WIDTH - `VEC_LEN_WIDTH){1'b0}}, length};
      `VEC_ADDR_MODE:   cfg_rdata = {{(`VEC_ACC_WIDTH - 1){1'b0}}, mode};
      `VEC_ADDR_STATUS: cfg_rdata = {{(`VEC_ACC_WIDTH - 1){1'b0}}, ovf_sticky};
      default:          cfg_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/dot_product/scalar_multiplier.sv
// Scalar multiplier
// Iterative signed shift-add, one multiplier bit per cycle

`default_nettype none

`include "vector_consts.svh"

module scalar_multiplier (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              start,
  input  logic signed [`VEC_DATA_WIDTH-1:0] a,
  input  logic signed [`VEC_DATA_WIDTH-1:0] b,
  output logic                              done,
  output logic signed [`VEC_ACC_WIDTH-1:0]  product
);

  localparam int STEP_WIDTH = $clog2(`VEC_DATA_WIDTH);
  localparam logic [STEP_WIDTH-1:0] LAST_STEP = STEP_WIDTH'(`VEC_DATA_WIDTH - 1);

  logic                        running;
  logic [STEP_WIDTH-1:0]       step;
  logic                        neg;
  logic [`VEC_DATA_WIDTH-1:0]  a_mag;
  logic [`VEC_DATA_WIDTH-1:0]  b_mag;
  logic [`VEC_ACC_WIDTH-1:0]   a_ext;
  logic [`VEC_ACC_WIDTH-1:0]   mcand;
  logic [`VEC_DATA_WIDTH-1:0]  mplier;
  logic [`VEC_ACC_WIDTH-1:0]   partial;
  logic [`VEC_ACC_WIDTH-1:0]   partial_next;

  // Magnitudes, -32768 maps to 0x8000 unsigned
  assign a_mag = a[`VEC_DATA_WIDTH-1] ? (~a + 1'b1) : a;
  assign b_mag = b[`VEC_DATA_WIDTH-1] ? (~b + 1'b1) : b;
  assign a_ext = {{(`VEC_ACC_WIDTH - `VEC_DATA_WIDTH){1'b0}}, a_mag};

  // Add shifted multiplicand when the current multiplier bit is set
  assign partial_next = partial + (mplier[0] ? mcand : '0);

  ////////////////////
  // Sequencing
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      running <= 1'b0;
      step    <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      if (!running) begin
        // Start while running is dropped
        if (start) begin
          running <= 1'b1;
          step    <= STEP_WIDTH'(1);
        end
      end else if (step == LAST_STEP) begin
        running <= 1'b0;
        done    <= 1'b1;
      end else begin
        step <= step + 1'b1;
      end
    end
  end

  ////////////////////
  // Datapath
  ////////////////////

  always_ff @(posedge CLK) begin
    if (!running) begin
      if (start) begin
        // Bit 0 is consumed in the launch cycle
        partial <= b_mag[0] ? a_ext : '0;
        mcand   <= a_ext << 1;
        mplier  <= b_mag >> 1;
        neg     <= a[`VEC_DATA_WIDTH-1] ^ b[`VEC_DATA_WIDTH-1];
      end
    end else if (step == LAST_STEP) begin
      // Last bit, apply the sign on the way out
      product <= neg ? -partial_next : partial_next;
    end else begin
      partial <= partial_next;
      mcand   <= mcand << 1;
      mplier  <= mplier >> 1;
    end
  end

endmodule

`default_nettype wire

//--- hw/dot_product/dot_product_ctrl.sv
// Dot product controller
// Requests element pairs, drives the multiplier, accumulates with
// saturation and strobes the final sum out

`default_nettype none

`include "vector_consts.svh"

module dot_product_ctrl (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              start,
  input  logic [`VEC_LEN_WIDTH-1:0]         length,
  input  vector_pkg::acc_mode_e             mode,
  output logic                              elem_req,
  input  logic                              a_valid,
  input  logic                              b_valid,
  input  logic signed [`VEC_DATA_WIDTH-1:0] a_data,
  input  logic signed [`VEC_DATA_WIDTH-1:0] b_data,
  output logic                              mul_start,
  output logic signed [`VEC_DATA_WIDTH-1:0] mul_a,
  output logic signed [`VEC_DATA_WIDTH-1:0] mul_b,
  input  logic                              mul_done,
  input  logic signed [`VEC_ACC_WIDTH-1:0]  mul_product,
  output logic                              busy,
  output logic                              done,
  output logic                              ovf,
  output logic signed [`VEC_ACC_WIDTH-1:0]  result
);

  import vector_pkg::*;

  localparam logic signed [`VEC_ACC_WIDTH-1:0] ACC_MAX = {1'b0, {(`VEC_ACC_WIDTH-1){1'b1}}};
  localparam logic signed [`VEC_ACC_WIDTH-1:0] ACC_MIN = {1'b1, {(`VEC_ACC_WIDTH-1){1'b0}}};

  ctrl_state_e                       state;
  acc_mode_e                         mode_q;
  logic [`VEC_LEN_WIDTH-1:0]         len_q;
  logic [`VEC_LEN_WIDTH-1:0]         idx;
  logic [`VEC_LEN_WIDTH-1:0]         idx_next;
  logic                              a_got;
  logic                              b_got;
  logic                              pair_done;
  logic signed [`VEC_DATA_WIDTH-1:0] a_q;
  logic signed [`VEC_DATA_WIDTH-1:0] b_q;
  logic signed [`VEC_ACC_WIDTH-1:0]  acc;
  logic signed [`VEC_ACC_WIDTH:0]    acc_wide;
  logic signed [`VEC_ACC_WIDTH-1:0]  acc_sat;
  logic                              clamp;

  // Strobes decoded straight from the state
  assign elem_req  = (state == REQUEST);
  assign mul_start = (state == MULTIPLY);
  assign busy      = (state != IDLE);
  assign mul_a     = a_q;
  assign mul_b     = b_q;

  // Pair is complete once both operands are held or arriving now
  assign pair_done = (a_got | a_valid) & (b_got | b_valid);
  assign idx_next  = idx + 1'b1;

  ////////////////////
  // Saturating add
  ////////////////////

  // One extra bit catches the carry out of the 32-bit range
  assign acc_wide = (mode_q == ACC_SUB) ?
                    ({acc[`VEC_ACC_WIDTH-1], acc} - {mul_product[`VEC_ACC_WIDTH-1], mul_product}) :
                    ({acc[`VEC_ACC_WIDTH-1], acc} + {mul_product[`VEC_ACC_WIDTH-1], mul_product});
  assign clamp    = acc_wide[`VEC_ACC_WIDTH] != acc_wide[`VEC_ACC_WIDTH-1];
  assign acc_sat  = clamp ? (acc_wide[`VEC_ACC_WIDTH] ? ACC_MIN : ACC_MAX) :
                    acc_wide[`VEC_ACC_WIDTH-1:0];

  ////////////////////
  // FSM
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state  <= IDLE;
      idx    <= '0;
      a_got  <= 1'b0;
      b_got  <= 1'b0;
      done   <= 1'b0;
      ovf    <= 1'b0;
      result <= '0;
    end else begin
      done <= 1'b0;
      ovf  <= 1'b0;
      case (state)
        IDLE: begin
          if (start) begin
            idx   <= '0;
            state <= REQUEST;
          end
        end
        REQUEST: begin
          // Fresh pair for this element
          a_got <= 1'b0;
          b_got <= 1'b0;
          state <= WAIT_ELEM;
        end
        WAIT_ELEM: begin
          if (a_valid) a_got <= 1'b1;
          if (b_valid) b_got <= 1'b1;
          if (pair_done) state <= MULTIPLY;
        end
        MULTIPLY: begin
          state <= ACCUMULATE;
        end
        ACCUMULATE: begin
          if (mul_done) begin
            ovf   <= clamp;
            state <= UPDATE_INDEX;
          end
        end
        UPDATE_INDEX: begin
          if (idx_next == len_q) begin
            // Last element, publish the sum
            done   <= 1'b1;
            result <= acc;
            state  <= IDLE;
          end else begin
            idx   <= idx_next;
            state <= REQUEST;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  ////////////////////
  // Operands and sum
  ////////////////////

  always_ff @(posedge CLK) begin
    if (state == IDLE && start) begin
      // Config is sampled once per operation
      len_q  <= length;
      mode_q <= mode;
      acc    <= '0;
    end
    // Repeated strobe overwrites the held operand
    if (state == WAIT_ELEM && a_valid) a_q <= a_data;
    if (state == WAIT_ELEM && b_valid) b_q <= b_data;
    if (state == ACCUMULATE && mul_done) acc <= acc_sat;
  end

endmodule

`default_nettype wire

//--- hw/vector_dot_top.sv
// Vector dot product top level
// Config registers, dot product controller and shift-add multiplier

`default_nettype none

`include "vector_consts.svh"

module vector_dot_top (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              cfg_we,
  input  logic [`VEC_CFG_ADDR_WIDTH-1:0]    cfg_addr,
  input  logic [`VEC_ACC_WIDTH-1:0]         cfg_wdata,
  output logic [`VEC_ACC_WIDTH-1:0]         cfg_rdata,
  input  logic                              start,
  output logic                              elem_req,
  input  logic                              a_valid,
  input  logic signed [`VEC_DATA_WIDTH-1:0] a_data,
  input  logic                              b_valid,
  input  logic signed [`VEC_DATA_WIDTH-1:0] b_data,
  output logic                              busy,
  output logic                              done,
  output logic signed [`VEC_ACC_WIDTH-1:0]  result
);

  import vector_pkg::*;

  // Config to controller
  logic [`VEC_LEN_WIDTH-1:0]         length;
  acc_mode_e                         mode;
  logic                              ovf;

  // Controller to multiplier
  logic                              mul_start;
  logic signed [`VEC_DATA_WIDTH-1:0] mul_a;
  logic signed [`VEC_DATA_WIDTH-1:0] mul_b;
  logic                              mul_done;
  logic signed [`VEC_ACC_WIDTH-1:0]  mul_product;

  vector_config_regs u_regs (
    .CLK       (CLK),
    .RST       (RST),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .ovf       (ovf),
    .length    (length),
    .mode      (mode)
  );

  dot_product_ctrl u_ctrl (
    .CLK         (CLK),
    .RST         (RST),
    .start       (start),
    .length      (length),
    .mode        (mode),
    .elem_req    (elem_req),
    .a_valid     (a_valid),
    .b_valid     (b_valid),
    .a_data      (a_data),
    .b_data      (b_data),
    .mul_start   (mul_start),
    .mul_a       (mul_a),
    .mul_b       (mul_b),
    .mul_done    (mul_done),
    .mul_product (mul_product),
    .busy        (busy),
    .done        (done),
    .ovf         (ovf),
    .result      (result)
  );

  scalar_multiplier u_mul (
    .CLK     (CLK),
    .RST     (RST),
    .start   (mul_start),
    .a       (mul_a),
    .b       (mul_b),
    .done    (mul_done),
    .product (mul_product)
  );

endmodule

`default_nettype wire

//--- dv/vector_dot_checker.sv
// Vector dot product checker
// Concurrent assertions on strobes, reset values and done latency

`default_nettype none

`include "vector_consts.svh"

module vector_dot_checker (
  input logic CLK,
  input logic RST,
  input logic start,
  input logic elem_req,
  input logic a_valid,
  input logic b_valid,
  input logic busy,
  input logic done
);

  int   fail_count = 0;
  logic pending;
  logic a_seen;
  logic b_seen;
  logic pair_fire;

  // Mirror of the operand pairing after each request
  assign pair_fire = pending & (a_seen | a_valid) & (b_seen | b_valid);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      pending <= 1'b0;
      a_seen  <= 1'b0;
      b_seen  <= 1'b0;
    end else if (elem_req) begin
      pending <= 1'b1;
      a_seen  <= 1'b0;
      b_seen  <= 1'b0;
    end else if (pair_fire) begin
      pending <= 1'b0;
    end else if (pending) begin
      a_seen <= a_seen | a_valid;
      b_seen <= b_seen | b_valid;
    end
  end

  ////////////////////
  // Properties
  ////////////////////

  no_done_with_req: assert property (@(posedge CLK) disable iff (RST) !(done && elem_req))
    else begin
      $error("done and elem_req high in the same cycle");
      fail_count++;
    end

  // Second reset cycle onward, flops are settled
  quiet_in_reset: assert property (@(posedge CLK) (RST && $past(RST)) |-> (!done && !elem_req && !busy))
    else begin
      $error("strobe or busy high during reset");
      fail_count++;
    end

  quiet_after_reset: assert property (@(posedge CLK) $fell(RST) |-> (!done && !elem_req && !busy))
    else begin
      $error("strobe or busy high in the cycle after reset");
      fail_count++;
    end

  // Multiplier run plus accumulate and index update, then next request or done
  pair_to_next: assert property (@(posedge CLK) disable iff (RST)
                                 pair_fire |-> ##(`VEC_DATA_WIDTH + 3) (done || elem_req))
    else begin
      $error("neither done nor the next request after the operand pair");
      fail_count++;
    end

  // Every done closes the last pair at a fixed distance
  done_latency: assert property (@(posedge CLK) disable iff (RST)
                                 done |-> $past(pair_fire, `VEC_DATA_WIDTH + 3))
    else begin
      $error("done not at the fixed latency after the last operand strobe");
      fail_count++;
    end

  busy_after_start: assert property (@(posedge CLK) disable iff (RST) (start && !busy) |=> busy)
    else begin
      $error("busy not raised after an accepted start");
      fail_count++;
    end

endmodule

`default_nettype wire

//--- dv/vector_dot_tb.sv
// Vector dot product testbench
// Config writes, element source with random pacing, scoreboard and watchdog

`default_nettype none

`include "vector_consts.svh"

module vector_dot_tb;

  localparam int     CLK_PERIOD      = 100;
  localparam int     NUM_TESTS       = 9;
  localparam int     WATCHDOG_CYCLES = NUM_TESTS * 255 * (`VEC_DATA_WIDTH + 8);
  localparam int     DW              = `VEC_DATA_WIDTH;
  localparam longint ACC_MAX         = 64'sd2147483647;
  localparam longint ACC_MIN         = -64'sd2147483648;

  logic                              CLK;
  logic                              RST;
  logic                              cfg_we;
  logic [`VEC_CFG_ADDR_WIDTH-1:0]    cfg_addr;
  logic [`VEC_ACC_WIDTH-1:0]         cfg_wdata;
  logic [`VEC_ACC_WIDTH-1:0]         cfg_rdata;
  logic                              start;
  logic                              elem_req;
  logic                              a_valid;
  logic signed [DW-1:0]              a_data;
  logic                              b_valid;
  logic signed [DW-1:0]              b_data;
  logic                              busy;
  logic                              done;
  logic signed [`VEC_ACC_WIDTH-1:0]  result;

  int seed         = 32416;
  int errors       = 0;
  int failed_tests = 0;
  int done_count   = 0;

  vector_dot_top u_vector_dot_top (
    .CLK       (CLK),
    .RST       (RST),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .start     (start),
    .elem_req  (elem_req),
    .a_valid   (a_valid),
    .a_data    (a_data),
    .b_valid   (b_valid),
    .b_data    (b_data),
    .busy      (busy),
    .done      (done),
    .result    (result)
  );

  bind vector_dot_top vector_dot_checker u_checker (
    .CLK      (CLK),
    .RST      (RST),
    .start    (start),
    .elem_req (elem_req),
    .a_valid  (a_valid),
    .b_valid  (b_valid),
    .busy     (busy),
    .done     (done)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // Count every done pulse
  always @(posedge CLK) begin
    if (!RST && done) done_count <= done_count + 1;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("Timeout after %0d cycles without finishing the tests", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  ////////////////////
  // Helpers
  ////////////////////

  function automatic int total_failures();
    return errors + u_vector_dot_top.u_checker.fail_count;
  endfunction

  function automatic longint clamp_acc(input longint value);
    if (value > ACC_MAX) return ACC_MAX;
    if (value < ACC_MIN) return ACC_MIN;
    return value;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("** Error: %s expected %h got %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic write_cfg(input logic [`VEC_CFG_ADDR_WIDTH-1:0] addr,
                           input logic [`VEC_ACC_WIDTH-1:0] data);
    cfg_we    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    @(posedge CLK);
    cfg_we <= 1'b0;
  endtask

  // Readback is combinational, so one edge settles it
  task automatic read_check(input string name, input logic [`VEC_CFG_ADDR_WIDTH-1:0] addr,
                            input logic [`VEC_ACC_WIDTH-1:0] expected);
    cfg_addr <= addr;
    @(posedge CLK);
    check_value(name, expected, cfg_rdata);
  endtask

  // Called on the edge that saw elem_req, delays of 1 to 4 cycles
  task automatic send_pair(input logic signed [DW-1:0] av, input logic signed [DW-1:0] bv);
    int da;
    int db;
    int t;
    da = 1 + (($random(seed) & 32'h7fffffff) % 4);
    db = 1 + (($random(seed) & 32'h7fffffff) % 4);
    for (t = 1; t <= ((da > db) ? da : db); t++) begin
      a_valid <= (t == da);
      b_valid <= (t == db);
      if (t == da) a_data <= av;
      if (t == db) b_data <= bv;
      @(posedge CLK);
    end
    a_valid <= 1'b0;
    b_valid <= 1'b0;
  endtask

  ////////////////////
  // One dot product
  ////////////////////

  task automatic run_dot(input string name, input int len, input bit sub, input bit use_random,
                         input logic signed [DW-1:0] fill, input bit poke_start);
    int                   n;
    int                   i;
    int                   fails_before;
    int                   dones_before;
    longint               exp_sum;
    longint               raw;
    bit                   exp_ovf;
    logic signed [DW-1:0] av;
    logic signed [DW-1:0] bv;
    fails_before = total_failures();
    n = (len == 0) ? 1 : len;
    exp_sum = 0;
    exp_ovf = 1'b0;
    write_cfg(`VEC_ADDR_LENGTH, len);
    write_cfg(`VEC_ADDR_MODE, sub);
    read_check("length", `VEC_ADDR_LENGTH, n);
    read_check("mode", `VEC_ADDR_MODE, sub);
    dones_before = done_count;
    start <= 1'b1;
    @(posedge CLK);
    start <= 1'b0;
    for (i = 0; i < n; i++) begin
      do @(posedge CLK); while (!elem_req);
      if (poke_start && i == 0) begin
        // Extra start while busy must be dropped
        start <= 1'b1;
        @(posedge CLK);
        start <= 1'b0;
      end
      if (use_random) begin
        av = $random(seed);
        bv = $random(seed);
      end else begin
        av = fill;
        bv = fill;
      end
      raw = sub ? exp_sum - longint'(av) * longint'(bv) : exp_sum + longint'(av) * longint'(bv);
      if (clamp_acc(raw) != raw) exp_ovf = 1'b1;
      exp_sum = clamp_acc(raw);
      send_pair(av, bv);
    end
    do @(posedge CLK); while (!done);
    check_value("result", exp_sum[31:0], result);
    repeat (3) @(posedge CLK);
    assert (done_count == dones_before + 1) else begin
      $display("Expected one done for the start but counted %0d", done_count - dones_before);
      errors++;
    end
    assert (!busy) else begin
      $display("Engine still busy after done");
      errors++;
    end
    read_check("status", `VEC_ADDR_STATUS, exp_ovf);
    write_cfg(`VEC_ADDR_STATUS, '0);
    read_check("status after clear", `VEC_ADDR_STATUS, '0);
    if (total_failures() != fails_before) failed_tests++;
    $display("test %-20s %s", name, (total_failures() != fails_before) ? "FAIL" : "PASS");
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    RST       = 1'b1;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    start     = 1'b0;
    a_valid   = 1'b0;
    a_data    = '0;
    b_valid   = 1'b0;
    b_data    = '0;
    repeat (2) @(posedge CLK);
    RST <= 1'b0;
    @(posedge CLK);
    run_dot("add len 1", 1, 1'b0, 1'b1, '0, 1'b0);
    run_dot("add len 2", 2, 1'b0, 1'b1, '0, 1'b0);
    run_dot("add len 7", 7, 1'b0, 1'b1, '0, 1'b0);
    run_dot("add len 32", 32, 1'b0, 1'b1, '0, 1'b0);
    run_dot("sub len 7", 7, 1'b1, 1'b1, '0, 1'b0);
    // 0x7FFF squared three times passes the positive limit
    run_dot("saturate add", 4, 1'b0, 1'b0, 16'sh7fff, 1'b0);
    run_dot("saturate sub", 4, 1'b1, 1'b0, 16'sh8000, 1'b0);
    run_dot("start while busy", 3, 1'b0, 1'b1, '0, 1'b1);
    run_dot("length zero", 0, 1'b0, 1'b1, '0, 1'b0);
    $display("tests %0d, failed %0d, check errors %0d, checker failures %0d",
             NUM_TESTS, failed_tests, errors, u_vector_dot_top.u_checker.fail_count);
    if (total_failures() == 0 && failed_tests == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+common
common/vector_pkg.sv
hw/vector_config_regs.sv
hw/dot_product/scalar_multiplier.sv
hw/dot_product/dot_product_ctrl.sv
hw/vector_dot_top.sv
dv/vector_dot_checker.sv
dv/vector_dot_tb.sv

//--- Bender.yml
package:
  name: vector_dot

sources:
  - include_dirs:
      - common
    files:
      - common/vector_pkg.sv
      - hw/vector_config_regs.sv
      - hw/dot_product/scalar_multiplier.sv
      - hw/dot_product/dot_product_ctrl.sv
      - hw/vector_dot_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/vector_dot_checker.sv
      - dv/vector_dot_tb.sv
